//--- logic/fetch_pkg.sv
// Shared definitions of the read fetch engine
// Bus and descriptor widths, defaults of the top-level parameters
// and the record kept for every read in flight
`default_nettype none

package fetch_pkg;

    // Bus and descriptor widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned WORD_W = 32;
    localparam int unsigned BEAT_W = 64;
    localparam int unsigned SIZE_W = 16;

    // Defaults for the top-level parameters
    localparam int unsigned NODES_DEF      = 4;
    localparam int unsigned FIFO_DEPTH_DEF = 10;
    localparam int unsigned MAX_OUTST_DEF  = 6;

    // One read in flight: target node and which half of the beat
    typedef struct packed {
        logic [NODES_DEF-1:0] node_sel;
        logic                 odd_word;
    } outst_rec_t;

endpackage

`default_nettype wire

//--- logic/rd_req_if.sv
// Granted read request between arbiter, address generator and control
// Modports for the address generator, the control and the top
`timescale 1ns/100ps
`default_nettype none

interface rd_req_if #(
    parameter int unsigned NUM_NODES = fetch_pkg::NODES_DEF
);

    logic [NUM_NODES-1:0]         grant;
    logic [fetch_pkg::ADDR_W-1:0] rd_addr;
    logic                         odd_word;
    logic                         new_req;

    modport req  (input grant, output rd_addr, output odd_word, output new_req);
    modport ctrl (input new_req, input rd_addr);
    // Outstanding record push in the top
    modport mon  (input grant, input odd_word, input new_req);

endinterface

`default_nettype wire

//--- logic/node_fifo.sv
// Synchronous FIFO with a type parameter for the payload
// Circular buffer of any depth with a usage count
`timescale 1ns/100ps
`default_nettype none

module node_fifo #(
    parameter int unsigned DEPTH = 8,
    parameter type payload_t = logic
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  payload_t                   data_i,
    input  logic                       push_i,
    output logic                       full_o,
    output payload_t                   data_o,
    input  logic                       pop_i,
    output logic                       empty_o,
    output logic [$clog2(DEPTH+1)-1:0] usage_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH-1:0];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_en;
    logic             pop_en;

    // Pointers wrap at DEPTH, not at a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign usage_o = count_q;
    assign data_o  = mem_q[rd_ptr_q];

    assign push_en = push_i & ~full_o;
    assign pop_en  = pop_i & ~empty_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop_en) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q <= count_q + CNT_W'(push_en) - CNT_W'(pop_en);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Upstream flow control must keep within the limits
    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
        else $error("push to full FIFO");
    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
        else $error("pop from empty FIFO");

endmodule

`default_nettype wire

//--- logic/rr_arbiter.sv
// Round-robin arbiter over a doubled request vector
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
    parameter int unsigned WIDTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [WIDTH-1:0] request_i,
    input  logic             enable_i,
    output logic [WIDTH-1:0] grant_o
);

    logic [WIDTH-1:0]   prev_rol_q;
    logic [2*WIDTH-1:0] double_req;
    logic [2*WIDTH-1:0] double_grant;

    // Subtracting the one-hot clears the first request at or above it,
    // the doubled copy covers the wrap-around
    assign double_req   = {request_i, request_i};
    assign double_grant = double_req & ~(double_req - {{WIDTH{1'b0}}, prev_rol_q});

    assign grant_o = enable_i ? (double_grant[WIDTH-1:0] | double_grant[2*WIDTH-1:WIDTH]) : '0;

    // Start search one above the last winner
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prev_rol_q <= WIDTH'(1);
        end else if (grant_o != '0) begin
            prev_rol_q <= (grant_o << 1) | (grant_o >> (WIDTH - 1));
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(grant_o) && ((grant_o & ~request_i) == '0))
        else $error("grant not one-hot or without request");

endmodule

`default_nettype wire

//--- logic/addr_gen.sv
// Per-node offset counters and request formation
// Read address computation and register on every grant
`timescale 1ns/100ps
`default_nettype none

module addr_gen #(
    parameter int unsigned NUM_NODES  = fetch_pkg::NODES_DEF,
    parameter int unsigned FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF,
    parameter int unsigned MAX_OUTST  = fetch_pkg::MAX_OUTST_DEF
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic [fetch_pkg::ADDR_W-1:0]    node_base_i   [NUM_NODES-1:0],
    input  logic [fetch_pkg::SIZE_W-1:0]    node_size_i   [NUM_NODES-1:0],
    input  logic [fetch_pkg::SIZE_W-1:0]    node_stride_i [NUM_NODES-1:0],
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_usage_i  [NUM_NODES-1:0],
    input  logic                            restart_i,
    output logic [NUM_NODES-1:0]            request_o,
    output logic                            nodes_pending_o,
    rd_req_if.req                           req_if
);

    // Spare bit so the last stride may step past the size
    localparam int unsigned OFFS_W = fetch_pkg::SIZE_W + 1;
    // Room left for every read that may still be in flight
    localparam int unsigned FILL_LIMIT = (FIFO_DEPTH > MAX_OUTST) ? FIFO_DEPTH - MAX_OUTST : 0;

    logic [OFFS_W-1:0]            offs_q [NUM_NODES-1:0];
    logic [OFFS_W-1:0]            offs_d [NUM_NODES-1:0];
    logic [NUM_NODES-1:0]         in_range;
    logic [fetch_pkg::ADDR_W-1:0] next_addr;
    logic [fetch_pkg::ADDR_W-1:0] rd_addr_q;

    always_comb begin
        for (int i = 0; i < NUM_NODES; i++) begin
            in_range[i]  = offs_q[i] < OFFS_W'(node_size_i[i]);
            request_o[i] = in_range[i] && (fifo_usage_i[i] < FILL_LIMIT);
        end
    end

    assign nodes_pending_o = |in_range;
    assign req_if.new_req  = |req_if.grant;

    always_comb begin
        next_addr = '0;
        offs_d    = offs_q;
        for (int i = 0; i < NUM_NODES; i++) begin
            if (req_if.grant[i]) begin
                next_addr = node_base_i[i]
                          + {{(fetch_pkg::ADDR_W - OFFS_W){1'b0}}, offs_q[i]};
                offs_d[i] = offs_q[i] + OFFS_W'(node_stride_i[i]);
            end
        end
        if (restart_i) begin
            offs_d = '{default: '0};
        end
    end

    // Bit 2 picks the word inside the 64-bit beat
    assign req_if.odd_word = next_addr[2];
    assign req_if.rd_addr  = rd_addr_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            offs_q <= '{default: '0};
        end else begin
            offs_q <= offs_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_if.new_req) begin
            rd_addr_q <= next_addr;
        end
    end

endmodule

`default_nettype wire

//--- logic/fetch_ctrl.sv
// Fetch control: execute flag and restart pulse,
// read-address channel holding and arbiter enable
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         execute_i,
    rd_req_if.ctrl                       req_if,
    input  logic                         outst_empty_i,
    input  logic                         outst_full_i,
    input  logic                         nodes_pending_i,
    input  logic                         ar_ready_i,
    output logic                         ar_valid_o,
    output logic [fetch_pkg::ADDR_W-1:0] ar_addr_o,
    output logic                         arb_enable_o,
    output logic                         busy_o,
    output logic                         restart_o
);

    logic busy_q;
    logic busy_d;
    logic wait_ar_q;
    logic wait_ar_d;
    logic ar_free;

    // Done once nothing is left to request and nothing is in flight
    always_comb begin
        busy_d = busy_q;
        if (execute_i) begin
            busy_d = 1'b1;
        end else if (!nodes_pending_i && outst_empty_i) begin
            busy_d = 1'b0;
        end
    end

    assign restart_o = busy_q & ~busy_d;
    assign busy_o    = busy_q;

    // Channel takes a new address when idle or accepted this cycle
    assign ar_free      = !wait_ar_q || ar_ready_i;
    assign wait_ar_d    = ar_free ? req_if.new_req : wait_ar_q;
    assign arb_enable_o = busy_q & ar_free & ~outst_full_i;

    assign ar_valid_o = wait_ar_q;
    // Beat-aligned
    assign ar_addr_o  = {req_if.rd_addr[fetch_pkg::ADDR_W-1:3], 3'b000};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q    <= 1'b0;
            wait_ar_q <= 1'b0;
        end else begin
            busy_q    <= busy_d;
            wait_ar_q <= wait_ar_d;
        end
    end

    // Address from addr_gen must hold until the slave takes it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else $error("read address changed while waiting");

endmodule

`default_nettype wire

//--- logic/read_return.sv
// Read return path: lane select of the returning beat
// and routing of the word into the node FIFOs
`timescale 1ns/100ps
`default_nettype none

module read_return #(
    parameter int unsigned NUM_NODES = fetch_pkg::NODES_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic [fetch_pkg::BEAT_W-1:0] r_data_i,
    input  logic                         r_valid_i,
    input  fetch_pkg::outst_rec_t        outst_head_i,
    input  logic [NUM_NODES-1:0]         node_full_i,
    output logic [fetch_pkg::WORD_W-1:0] word_o,
    output logic [NUM_NODES-1:0]         push_o,
    output logic                         outst_pop_o
);

    // Every beat belongs to the oldest record, so one word feeds all FIFOs
    assign word_o = outst_head_i.odd_word ? r_data_i[fetch_pkg::WORD_W +: fetch_pkg::WORD_W]
                                          : r_data_i[fetch_pkg::WORD_W-1:0];

    assign push_o      = r_valid_i ? outst_head_i.node_sel : '0;
    assign outst_pop_o = r_valid_i;

    // FIFO headroom reserved at request time
    assert property (@(posedge clk_i) disable iff (!rst_ni) (push_o & node_full_i) == '0)
        else $error("return word for a full node FIFO");
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        r_valid_i |-> $onehot(outst_head_i.node_sel))
        else $error("read beat without a valid outstanding record");

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
// Top level of the read fetch engine
// Address generator, arbiter, control, return path,
// outstanding FIFO and one word FIFO per node
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter int unsigned NUM_NODES  = fetch_pkg::NODES_DEF,
    parameter int unsigned FIFO_DEPTH = fetch_pkg::FIFO_DEPTH_DEF,
    parameter int unsigned MAX_OUTST  = fetch_pkg::MAX_OUTST_DEF
) (
    input  logic                                  clk_i,
    input  logic                                  rst_ni,
    input  logic                                  execute_i,
    input  logic [fetch_pkg::ADDR_W-1:0]          node_base_i   [NUM_NODES-1:0],
    input  logic [fetch_pkg::SIZE_W-1:0]          node_size_i   [NUM_NODES-1:0],
    input  logic [fetch_pkg::SIZE_W-1:0]          node_stride_i [NUM_NODES-1:0],
    output logic [fetch_pkg::ADDR_W-1:0]          ar_addr_o,
    output logic                                  ar_valid_o,
    input  logic                                  ar_ready_i,
    input  logic [fetch_pkg::BEAT_W-1:0]          r_data_i,
    input  logic                                  r_valid_i,
    output logic [NUM_NODES*fetch_pkg::WORD_W-1:0] node_data_o,
    output logic [NUM_NODES-1:0]                  node_valid_o,
    input  logic [NUM_NODES-1:0]                  node_ready_i,
    output logic                                  busy_o
);

    rd_req_if #(.NUM_NODES(NUM_NODES)) req_if ();

    logic [NUM_NODES-1:0]            request;
    logic [NUM_NODES-1:0]            push;
    logic [NUM_NODES-1:0]            node_full;
    logic [NUM_NODES-1:0]            node_empty;
    logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_usage [NUM_NODES-1:0];
    logic                            nodes_pending;
    logic                            arb_enable;
    logic                            restart;
    fetch_pkg::outst_rec_t           outst_in;
    fetch_pkg::outst_rec_t           outst_head;
    logic                            outst_pop;
    logic                            outst_empty;
    logic                            outst_full;
    logic [fetch_pkg::WORD_W-1:0]    ret_word;

    // Record of the read granted this cycle
    assign outst_in.node_sel = req_if.grant;
    assign outst_in.odd_word = req_if.odd_word;

    assign node_valid_o = ~node_empty;

    addr_gen #(
        .NUM_NODES  ( NUM_NODES  ),
        .FIFO_DEPTH ( FIFO_DEPTH ),
        .MAX_OUTST  ( MAX_OUTST  )
    ) i_addr_gen (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .node_base_i     ( node_base_i   ),
        .node_size_i     ( node_size_i   ),
        .node_stride_i   ( node_stride_i ),
        .fifo_usage_i    ( fifo_usage    ),
        .restart_i       ( restart       ),
        .request_o       ( request       ),
        .nodes_pending_o ( nodes_pending ),
        .req_if          ( req_if        )
    );

    rr_arbiter #(
        .WIDTH ( NUM_NODES )
    ) i_rr_arbiter (
        .clk_i     ( clk_i        ),
        .rst_ni    ( rst_ni       ),
        .request_i ( request      ),
        .enable_i  ( arb_enable   ),
        .grant_o   ( req_if.grant )
    );

    fetch_ctrl i_fetch_ctrl (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .execute_i       ( execute_i     ),
        .req_if          ( req_if        ),
        .outst_empty_i   ( outst_empty   ),
        .outst_full_i    ( outst_full    ),
        .nodes_pending_i ( nodes_pending ),
        .ar_ready_i      ( ar_ready_i    ),
        .ar_valid_o      ( ar_valid_o    ),
        .ar_addr_o       ( ar_addr_o     ),
        .arb_enable_o    ( arb_enable    ),
        .busy_o          ( busy_o        ),
        .restart_o       ( restart       )
    );

    read_return #(
        .NUM_NODES ( NUM_NODES )
    ) i_read_return (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .r_data_i     ( r_data_i   ),
        .r_valid_i    ( r_valid_i  ),
        .outst_head_i ( outst_head ),
        .node_full_i  ( node_full  ),
        .word_o       ( ret_word   ),
        .push_o       ( push       ),
        .outst_pop_o  ( outst_pop  )
    );

    // Reads in flight, oldest at the head
    node_fifo #(
        .DEPTH     ( MAX_OUTST              ),
        .payload_t ( fetch_pkg::outst_rec_t )
    ) i_outst_fifo (
        .clk_i   ( clk_i          ),
        .rst_ni  ( rst_ni         ),
        .data_i  ( outst_in       ),
        .push_i  ( req_if.new_req ),
        .full_o  ( outst_full     ),
        .data_o  ( outst_head     ),
        .pop_i   ( outst_pop      ),
        .empty_o ( outst_empty    ),
        .usage_o (                )
    );

    for (genvar i = 0; i < NUM_NODES; i++) begin : g_node_fifo
        node_fifo #(
            .DEPTH     ( FIFO_DEPTH                     ),
            .payload_t ( logic [fetch_pkg::WORD_W-1:0] )
        ) i_node_fifo (
            .clk_i   ( clk_i                                                ),
            .rst_ni  ( rst_ni                                               ),
            .data_i  ( ret_word                                             ),
            .push_i  ( push[i]                                              ),
            .full_o  ( node_full[i]                                         ),
            .data_o  ( node_data_o[i*fetch_pkg::WORD_W +: fetch_pkg::WORD_W] ),
            .pop_i   ( node_valid_o[i] & node_ready_i[i]                    ),
            .empty_o ( node_empty[i]                                        ),
            .usage_o ( fifo_usage[i]                                        )
        );
    end

endmodule

`default_nettype wire

//--- bench/tb_fetch.sv
// Testbench of the read fetch engine
// Clock and reset, memory model with random read latency,
// back-pressure from an xorshift generator, descriptors and
// expected word streams built from bench/fetch_input.txt
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;

    localparam int unsigned NODES     = fetch_pkg::NODES_DEF;
    localparam int unsigned VEC_LEN   = 15;
    localparam int unsigned NUM_VEC   = 5;
    localparam int unsigned MAX_WORDS = 64;
    localparam int BUSY_LIMIT  = 5000;
    localparam int DRAIN_LIMIT = 2000;

    logic                                  clk_i;
    logic                                  rst_ni;
    logic                                  execute;
    logic [fetch_pkg::ADDR_W-1:0]          node_base   [NODES-1:0];
    logic [fetch_pkg::SIZE_W-1:0]          node_size   [NODES-1:0];
    logic [fetch_pkg::SIZE_W-1:0]          node_stride [NODES-1:0];
    logic [fetch_pkg::ADDR_W-1:0]          ar_addr;
    logic                                  ar_valid;
    logic                                  ar_ready;
    logic [fetch_pkg::BEAT_W-1:0]          r_data;
    logic                                  r_valid;
    logic [NODES*fetch_pkg::WORD_W-1:0]    node_data;
    logic [NODES-1:0]                      node_valid;
    logic [NODES-1:0]                      node_ready;
    logic                                  busy;

    logic [31:0] vec_mem [0:NUM_VEC*VEC_LEN-1];
    logic [31:0] exp_words [NODES][MAX_WORDS];
    int          exp_cnt [NODES];
    int          got_cnt [NODES];
    // Memory model queues of accepted beat addresses and their return cycles
    logic [31:0] mem_addr_q [$];
    int          mem_due_q [$];
    logic [31:0] rng_state;
    int          cycle_cnt;
    int          beats_returned;
    int          err_count;
    int          tests_run;
    int          tests_bad;
    int          ar_pct;
    int          node_pct;
    bit          timed_out;
    bit          file_ok;
    logic        hold_pending;
    logic [31:0] hold_addr;

    fetch_top #(
        .NUM_NODES  ( NODES                    ),
        .FIFO_DEPTH ( fetch_pkg::FIFO_DEPTH_DEF ),
        .MAX_OUTST  ( fetch_pkg::MAX_OUTST_DEF  )
    ) i_dut (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .execute_i     ( execute     ),
        .node_base_i   ( node_base   ),
        .node_size_i   ( node_size   ),
        .node_stride_i ( node_stride ),
        .ar_addr_o     ( ar_addr     ),
        .ar_valid_o    ( ar_valid    ),
        .ar_ready_i    ( ar_ready    ),
        .r_data_i      ( r_data      ),
        .r_valid_i     ( r_valid     ),
        .node_data_o   ( node_data   ),
        .node_valid_o  ( node_valid  ),
        .node_ready_i  ( node_ready  ),
        .busy_o        ( busy        )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Memory content is the address rotated left by 7 and XORed with a constant
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[24:0], addr[31:25]} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // True with a probability of pct percent
    function automatic logic chance(input int pct);
        return (next_rand() % 100) < pct;
    endfunction

    function automatic bit all_delivered();
        for (int i = 0; i < NODES; i++) begin
            if (got_cnt[i] != exp_cnt[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic log_error(input string msg);
        $display("FAIL t=%0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic report_test(input int num, input int errs_before, input int words);
        tests_run++;
        if (err_count != errs_before) begin
            tests_bad++;
        end
        $display("test %0d: %0d words checked, %0d errors", num, words, err_count - errs_before);
    endtask

    // Back-pressure and read data driven on the rising edge
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (rst_ni) begin
            ar_ready <= chance(ar_pct);
            // Even nodes see random back-pressure while odd nodes keep draining
            for (int i = 0; i < NODES; i++) begin
                if (i % 2 == 0) begin
                    node_ready[i] <= chance(node_pct);
                end else begin
                    node_ready[i] <= 1'b1;
                end
            end
            if (mem_addr_q.size() != 0 && cycle_cnt >= mem_due_q[0]) begin
                r_valid <= 1'b1;
                r_data  <= {mem_word(mem_addr_q[0] + 32'd4), mem_word(mem_addr_q[0])};
                void'(mem_addr_q.pop_front());
                void'(mem_due_q.pop_front());
                beats_returned++;
            end else begin
                r_valid <= 1'b0;
            end
        end
    end

    // Sampled mid-cycle as the DUT will see them at the next edge
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (hold_pending && (!ar_valid || ar_addr != hold_addr)) begin
                log_error($sformatf("ar_addr_o left %h while waiting for ar_ready_i", hold_addr));
            end
            hold_pending = ar_valid && !ar_ready;
            hold_addr    = ar_addr;
            if (ar_valid && ar_ready) begin
                mem_addr_q.push_back(ar_addr);
                mem_due_q.push_back(cycle_cnt + 2 + int'(next_rand() % 4));
            end
            for (int i = 0; i < NODES; i++) begin
                if (node_valid[i] && node_ready[i]) begin
                    if (got_cnt[i] >= exp_cnt[i]) begin
                        log_error($sformatf("node %0d gave extra word %h", i,
                                            node_data[i*32 +: 32]));
                    end else begin
                        if (node_data[i*32 +: 32] != exp_words[i][got_cnt[i]]) begin
                            log_error($sformatf("node %0d word %0d is %h, expected %h", i,
                                                got_cnt[i], node_data[i*32 +: 32],
                                                exp_words[i][got_cnt[i]]));
                        end
                        got_cnt[i]++;
                    end
                end
            end
        end
    end

    task automatic check_idle();
        int errs_before;
        errs_before = err_count;
        for (int c = 0; c < 8; c++) begin
            @(negedge clk_i);
            if (ar_valid || busy || node_valid != '0) begin
                log_error("outputs not idle after reset");
            end
        end
        report_test(1, errs_before, 0);
    endtask

    task automatic run_vector(input int v);
        int          idx;
        int          test_num;
        int          errs_before;
        int          total;
        int          t;
        logic [31:0] base;
        logic [31:0] size;
        logic [31:0] stride;
        logic [31:0] off;
        idx         = v * VEC_LEN;
        test_num    = int'(vec_mem[idx]);
        errs_before = err_count;
        total       = 0;
        ar_pct      = int'(vec_mem[idx + 13]);
        node_pct    = int'(vec_mem[idx + 14]);
        beats_returned = 0;
        // Expected stream holds one word per stride step below the size
        for (int i = 0; i < NODES; i++) begin
            base       = vec_mem[idx + 1 + 3*i];
            size       = vec_mem[idx + 2 + 3*i];
            stride     = vec_mem[idx + 3 + 3*i];
            exp_cnt[i] = 0;
            got_cnt[i] = 0;
            off        = 0;
            while (off < size && exp_cnt[i] < MAX_WORDS) begin
                exp_words[i][exp_cnt[i]] = mem_word(base + off);
                exp_cnt[i]++;
                off = off + stride;
            end
            total += exp_cnt[i];
        end
        @(posedge clk_i);
        for (int i = 0; i < NODES; i++) begin
            node_base[i]   <= vec_mem[idx + 1 + 3*i];
            node_size[i]   <= vec_mem[idx + 2 + 3*i][15:0];
            node_stride[i] <= vec_mem[idx + 3 + 3*i][15:0];
        end
        execute <= 1'b1;
        @(posedge clk_i);
        execute <= 1'b0;
        @(negedge clk_i);
        if (!busy) begin
            log_error("busy_o not high one cycle after execute");
        end
        for (t = 0; t < BUSY_LIMIT; t++) begin
            @(negedge clk_i);
            if (!busy) begin
                break;
            end
        end
        if (t == BUSY_LIMIT) begin
            $display("test %0d: timed out waiting for busy_o to fall", test_num);
            timed_out = 1'b1;
            return;
        end
        if (mem_addr_q.size() != 0 || beats_returned != total) begin
            log_error($sformatf("busy_o fell after %0d of %0d beats", beats_returned, total));
        end
        for (t = 0; t < DRAIN_LIMIT; t++) begin
            @(posedge clk_i);
            if (all_delivered()) begin
                break;
            end
        end
        if (t == DRAIN_LIMIT) begin
            $display("test %0d: timed out waiting for the node words", test_num);
            timed_out = 1'b1;
            return;
        end
        repeat (4) @(negedge clk_i);
        if (node_valid != '0) begin
            log_error("node FIFOs still hold words after the stream ended");
        end
        report_test(test_num, errs_before, total);
    endtask

    initial begin
        rst_ni       = 1'b0;
        execute      = 1'b0;
        ar_ready     = 1'b0;
        r_valid      = 1'b0;
        r_data       = '0;
        node_ready   = '0;
        for (int i = 0; i < NODES; i++) begin
            node_base[i]   = '0;
            node_size[i]   = '0;
            node_stride[i] = '0;
        end
        rng_state    = 32'h44fe_0285;
        cycle_cnt    = 0;
        err_count    = 0;
        tests_run    = 0;
        tests_bad    = 0;
        ar_pct       = 0;
        node_pct     = 0;
        timed_out    = 1'b0;
        hold_pending = 1'b0;
        $readmemh("bench/fetch_input.txt", vec_mem);
        file_ok = !$isunknown(vec_mem[0]);
        if (!file_ok) begin
            $display("stimulus file bench/fetch_input.txt could not be read");
            err_count++;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        check_idle();
        for (int v = 0; v < NUM_VEC && file_ok && !timed_out; v++) begin
            run_vector(v);
        end
        $display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_bad,
                 err_count);
        if (err_count == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/fetch_input.txt
// test | node0 base size stride | node1 ... | node2 ... | node3 ... | ar_ready % | node_ready %
// all values hex, ready probabilities in percent (64 = always ready)
00000002 00001000 0020 0004 00002000 0040 0008 00003000 0030 0004 00004000 0010 0004 64 64
00000003 00001004 0030 0004 00002104 0060 000c 0000300c 0024 000c 00004014 0028 0004 64 64
00000004 00005000 0040 0004 00006008 0048 000c 00007004 0020 0008 00008000 003c 0004 32 64
00000005 00009000 0050 0004 0000a00c 0030 000c 0000b000 0040 0008 0000c004 002c 0004 50 1e
00000006 00000100 0018 0004 00000204 0024 000c 00000300 0010 0008 00000408 0020 0004 4b 4b

//--- flist.f
logic/fetch_pkg.sv
logic/rd_req_if.sv
logic/node_fifo.sv
logic/rr_arbiter.sv
logic/addr_gen.sv
logic/fetch_ctrl.sv
logic/read_return.sv
logic/fetch_top.sv
bench/tb_fetch.sv

//--- Bender.yml
package:
  name: fetch_engine

sources:
  - logic/fetch_pkg.sv
  - logic/rd_req_if.sv
  - logic/node_fifo.sv
  - logic/rr_arbiter.sv
  - logic/addr_gen.sv
  - logic/fetch_ctrl.sv
  - logic/read_return.sv
  - logic/fetch_top.sv
  - target: test
    files:
      - bench/tb_fetch.sv
